/* rv_pkg.sv */
// RV64I core shared types
`default_nettype none

package rv_pkg;

  localparam int XLEN = 64;

  typedef enum logic [3:0] {
    ALU_ADD      = 4'b0000,
    ALU_COPY_IMM = 4'b0011,
    ALU_ADDW     = 4'b1001,
    ALU_EBREAK   = 4'b1110,
    ALU_NONE     = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_WORD   = 3'b100,
    MEM_DOUBLE = 3'b110,
    MEM_NONE   = 3'b111
  } mem_op_e;

  typedef enum logic {
    ASRC_RS1 = 1'b0,
    ASRC_PC  = 1'b1
  } asrc_e;

  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10
  } bsrc_e;

  typedef struct packed {
    logic    reg_wr;
    asrc_e   asrc;
    bsrc_e   bsrc;
    alu_op_e alu_op;
    logic    pc_jump;
    logic    pc_base_rs1;
    logic    mem_to_reg;
    logic    mem_wr;
    mem_op_e mem_op;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    logic            valid;
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [7:0]      mask;
  } dmem_req_t;

  typedef enum logic [1:0] {
    PH_FETCH = 2'b00,
    PH_EXEC  = 2'b01,
    PH_MEM   = 2'b10
  } phase_e;

endpackage

`default_nettype wire

/* mux_key.sv */
// Keyed lookup with default
`timescale 1ns/1ps
`default_nettype none

module mux_key #(
  parameter int  NR_KEY  = 2,
  parameter int  KEY_LEN = 1,
  parameter type data_t  = logic
) (
  input  wire [KEY_LEN-1:0]                             i_key,
  input  wire [NR_KEY-1:0][KEY_LEN+$bits(data_t)-1:0]   i_lut,
  input  wire data_t                                    i_default,
  output data_t                                         o_out
);

  localparam int DATA_LEN = $bits(data_t);

  // each entry holds the key in its upper bits and the value below it.
  always_comb begin
    o_out = i_default;
    for (int i = 0; i < NR_KEY; i++) begin
      if (i_lut[i][KEY_LEN+DATA_LEN-1 -: KEY_LEN] == i_key) begin
        o_out = data_t'(i_lut[i][DATA_LEN-1:0]);
      end
    end
  end

endmodule

`default_nettype wire

/* idu.sv */
// Instruction decode unit
`timescale 1ns/1ps
`default_nettype none

module idu import rv_pkg::*; (
  input  wire [31:0]      i_inst,
  output logic [XLEN-1:0] o_imm,
  output logic [4:0]      o_ra,
  output logic [4:0]      o_rb,
  output logic [4:0]      o_rd,
  output ctrl_t           o_ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_j;
  logic            inst_lui;
  logic            inst_auipc;
  logic            inst_jal;
  logic            inst_jalr;
  logic            inst_lw;
  logic            inst_sw;
  logic            inst_addi;
  logic            inst_ebreak;
  logic            inst_sd;
  logic            inst_addw;
  logic            type_i;
  logic            type_u;
  logic            type_s;
  logic            type_j;
  logic            alu_plus;
  mem_op_e         mem_op;
  alu_op_e         alu_op;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  assign inst_lui    = (opcode == 7'b0110111);
  assign inst_auipc  = (opcode == 7'b0010111);
  assign inst_jal    = (opcode == 7'b1101111);
  assign inst_jalr   = (opcode == 7'b1100111) && (funct3 == 3'b000);
  assign inst_lw     = (opcode == 7'b0000011) && (funct3 == 3'b010);
  assign inst_sw     = (opcode == 7'b0100011) && (funct3 == 3'b010);
  assign inst_addi   = (opcode == 7'b0010011) && (funct3 == 3'b000);
  assign inst_sd     = (opcode == 7'b0100011) && (funct3 == 3'b011);
  assign inst_addw   = (opcode == 7'b0111011) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  // only the exact encoding counts, so ecall falls through as a no-op.
  assign inst_ebreak = (i_inst == 32'h0010_0073);

  assign type_i = inst_lw || inst_addi || inst_ebreak || inst_jalr;
  assign type_u = inst_lui || inst_auipc;
  assign type_s = inst_sw || inst_sd;
  assign type_j = inst_jal;

  // r-type and unknown encodings leave the immediate at zero.
  mux_key #(.NR_KEY(4), .KEY_LEN(4), .data_t(logic [XLEN-1:0])) u_imm_mux (
    .i_key     ({type_i, type_u, type_s, type_j}),
    .i_lut     ({4'b1000, imm_i,
                 4'b0100, imm_u,
                 4'b0010, imm_s,
                 4'b0001, imm_j}),
    .i_default ('0),
    .o_out     (o_imm)
  );

  mux_key #(.NR_KEY(2), .KEY_LEN(2), .data_t(mem_op_e)) u_mem_mux (
    .i_key     ({inst_lw || inst_sw, inst_sd}),
    .i_lut     ({2'b10, MEM_WORD,
                 2'b01, MEM_DOUBLE}),
    .i_default (MEM_NONE),
    .o_out     (mem_op)
  );

  assign alu_plus = inst_auipc || inst_jal || inst_jalr || inst_lw || inst_sw ||
                    inst_addi || inst_sd;

  mux_key #(.NR_KEY(4), .KEY_LEN(4), .data_t(alu_op_e)) u_alu_mux (
    .i_key     ({inst_lui, alu_plus, inst_addw, inst_ebreak}),
    .i_lut     ({4'b1000, ALU_COPY_IMM,
                 4'b0100, ALU_ADD,
                 4'b0010, ALU_ADDW,
                 4'b0001, ALU_EBREAK}),
    .i_default (ALU_NONE),
    .o_out     (alu_op)
  );

  always_comb begin
    o_ctrl.reg_wr = inst_lui || inst_auipc || inst_jal || inst_jalr ||
                    inst_lw || inst_addi || inst_addw;
    o_ctrl.asrc   = (inst_jal || inst_jalr || inst_auipc) ? ASRC_PC : ASRC_RS1;
    // jumps add four to pc for the link value.
    if (inst_jal || inst_jalr) begin
      o_ctrl.bsrc = BSRC_FOUR;
    end else if (type_i || type_u || type_s) begin
      o_ctrl.bsrc = BSRC_IMM;
    end else begin
      o_ctrl.bsrc = BSRC_RS2;
    end
    o_ctrl.alu_op      = alu_op;
    o_ctrl.pc_jump     = inst_jal || inst_jalr;
    o_ctrl.pc_base_rs1 = inst_jalr;
    o_ctrl.mem_to_reg  = inst_lw;
    o_ctrl.mem_wr      = type_s;
    o_ctrl.mem_op      = mem_op;
    o_ctrl.halt        = inst_ebreak;
  end

endmodule

`default_nettype wire

/* ifu.sv */
// Fetch and sequencing unit
`timescale 1ns/1ps
`default_nettype none

module ifu import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire [31:0]      i_inst,
  input  wire ctrl_t      i_ctrl,
  input  wire [XLEN-1:0]  i_imm,
  input  wire [XLEN-1:0]  i_rs1,
  output logic [XLEN-1:0] o_pc,
  output logic [31:0]     o_ir,
  output phase_e          o_phase,
  output logic            o_ifetch,
  output logic            o_halt
);

  logic [XLEN-1:0] jump_base;
  logic [XLEN-1:0] next_pc;

  assign jump_base = i_ctrl.pc_base_rs1 ? i_rs1 : o_pc;
  // jump targets always have bit 0 cleared, as jalr requires.
  assign next_pc   = i_ctrl.pc_jump ? ((jump_base + i_imm) & ~64'd1) : (o_pc + 64'd4);
  assign o_ifetch  = (o_phase == PH_FETCH) && !o_halt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc    <= RESET_PC;
      o_phase <= PH_FETCH;
      o_halt  <= 1'b0;
    end else begin
      case (o_phase)
        PH_FETCH: begin
          if (!o_halt) begin
            o_phase <= PH_EXEC;
          end
        end
        PH_EXEC: begin
          if (i_ctrl.halt) begin
            o_halt  <= 1'b1;
            o_phase <= PH_FETCH;
          end else if (i_ctrl.mem_to_reg) begin
            o_phase <= PH_MEM;
          end else begin
            o_pc    <= next_pc;
            o_phase <= PH_FETCH;
          end
        end
        default: begin
          o_pc    <= next_pc;
          o_phase <= PH_FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ifetch) begin
      o_ir <= i_inst;
    end
  end

endmodule

`default_nettype wire

/* regfile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_pkg::*; (
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire [4:0]       i_ra,
  input  wire [4:0]       i_rb,
  input  wire [4:0]       i_rd,
  input  wire             i_we,
  input  wire [XLEN-1:0]  i_wdata,
  output logic [XLEN-1:0] o_rs1,
  output logic [XLEN-1:0] o_rs2
);

  logic [XLEN-1:0] regs [0:31];

  // x0 is never written, so it keeps the value from reset.
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // reads are combinational and x0 always reads as zero
  assign o_rs1 = (i_ra == 5'd0) ? '0 : regs[i_ra];
  assign o_rs2 = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

`default_nettype wire

/* alu.sv */
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
  input  wire ctrl_t      i_ctrl,
  input  wire [XLEN-1:0]  i_pc,
  input  wire [XLEN-1:0]  i_rs1,
  input  wire [XLEN-1:0]  i_rs2,
  input  wire [XLEN-1:0]  i_imm,
  output logic [XLEN-1:0] o_result
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] sum;

  assign op_a = (i_ctrl.asrc == ASRC_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.bsrc)
      BSRC_RS2:  op_b = i_rs2;
      BSRC_IMM:  op_b = i_imm;
      BSRC_FOUR: op_b = 64'd4;
      default:   op_b = '0;
    endcase
  end

  assign sum = op_a + op_b;

  // the same adder gives the link value and the memory address.
  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:      o_result = sum;
      ALU_ADDW:     o_result = {{32{sum[31]}}, sum[31:0]};
      ALU_COPY_IMM: o_result = i_imm;
      default:      o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* lsu.sv */
// Load and store unit
`timescale 1ns/1ps
`default_nettype none

module lsu import rv_pkg::*; (
  input  wire ctrl_t      i_ctrl,
  input  wire [XLEN-1:0]  i_addr,
  input  wire [XLEN-1:0]  i_rs2,
  input  wire             i_exec,
  input  wire [XLEN-1:0]  i_rdata,
  output dmem_req_t       o_dmem,
  output logic [XLEN-1:0] o_load
);

  logic        upper_word;
  logic [31:0] load_word;

  assign upper_word = i_addr[2];

  always_comb begin
    o_dmem.valid = i_exec && (i_ctrl.mem_op != MEM_NONE);
    o_dmem.we    = i_ctrl.mem_wr;
    o_dmem.addr  = i_addr;
    case (i_ctrl.mem_op)
      MEM_WORD: begin
        // a word goes out on both halves and the mask picks one.
        o_dmem.wdata = {2{i_rs2[31:0]}};
        o_dmem.mask  = upper_word ? 8'hf0 : 8'h0f;
      end
      MEM_DOUBLE: begin
        o_dmem.wdata = i_rs2;
        o_dmem.mask  = 8'hff;
      end
      default: begin
        o_dmem.wdata = '0;
        o_dmem.mask  = '0;
      end
    endcase
  end

  assign load_word = upper_word ? i_rdata[63:32] : i_rdata[31:0];

  assign o_load = (i_ctrl.mem_op == MEM_WORD) ? {{32{load_word[31]}}, load_word} : i_rdata;

endmodule

`default_nettype wire

/* core_top.sv */
// RV64I multi-cycle core
`timescale 1ns/1ps
`default_nettype none

module core_top import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire [31:0]      i_inst,
  input  wire [XLEN-1:0]  i_rdata,
  output logic [XLEN-1:0] o_pc,
  output logic            o_ifetch,
  output dmem_req_t       o_dmem,
  output logic            o_halt
);

  logic [31:0]     ir;
  phase_e          phase;
  ctrl_t           ctrl;
  logic [XLEN-1:0] imm;
  logic [4:0]      ra;
  logic [4:0]      rb;
  logic [4:0]      rd;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] load;
  logic            rf_we;
  logic [XLEN-1:0] rf_wdata;

  ifu #(.RESET_PC(RESET_PC)) u_ifu (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_inst   (i_inst),
    .i_ctrl   (ctrl),
    .i_imm    (imm),
    .i_rs1    (rs1),
    .o_pc     (o_pc),
    .o_ir     (ir),
    .o_phase  (phase),
    .o_ifetch (o_ifetch),
    .o_halt   (o_halt)
  );

  idu u_idu (
    .i_inst (ir),
    .o_imm  (imm),
    .o_ra   (ra),
    .o_rb   (rb),
    .o_rd   (rd),
    .o_ctrl (ctrl)
  );

  // loads write back in the mem phase, everything else at the end of exec.
  assign rf_we = ((phase == PH_EXEC) && ctrl.reg_wr && !ctrl.mem_to_reg) ||
                 ((phase == PH_MEM) && ctrl.mem_to_reg);
  assign rf_wdata = ctrl.mem_to_reg ? load : result;

  regfile u_regfile (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_ra    (ra),
    .i_rb    (rb),
    .i_rd    (rd),
    .i_we    (rf_we),
    .i_wdata (rf_wdata),
    .o_rs1   (rs1),
    .o_rs2   (rs2)
  );

  alu u_alu (
    .i_ctrl   (ctrl),
    .i_pc     (o_pc),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_imm    (imm),
    .o_result (result)
  );

  lsu u_lsu (
    .i_ctrl  (ctrl),
    .i_addr  (result),
    .i_rs2   (rs2),
    .i_exec  (phase == PH_EXEC),
    .i_rdata (i_rdata),
    .o_dmem  (o_dmem),
    .o_load  (load)
  );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

/* tb_checker.sv */
// Reference model and checker
`timescale 1ns/1ps
`default_nettype none

module tb_checker import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire [XLEN-1:0]  i_pc,
  input  wire             i_ifetch,
  input  wire [31:0]      i_inst,
  input  wire dmem_req_t  i_dmem,
  input  wire             i_halt,
  output int              o_errors,
  output int              o_checks
);

  logic [XLEN-1:0] ref_pc;
  logic [XLEN-1:0] ref_regs [0:31];
  logic [XLEN-1:0] ref_mem [0:255];
  logic            ref_halted;
  logic            halt_seen;
  logic            first_cycle = 1'b0;
  logic            req_pending;
  dmem_req_t       exp_req;

  initial begin
    o_errors = 0;
    o_checks = 0;
  end

  // initial data memory contents, shared with the memory model in tb_top.
  function automatic logic [XLEN-1:0] fill_word(input int unsigned idx);
    logic [31:0] a;
    a = idx * 32'h9e37_79b9;
    return {a ^ 32'h8000_0000, a + idx};
  endfunction

  function automatic logic [XLEN-1:0] byte_lanes(input logic [7:0] mask);
    logic [XLEN-1:0] keep;
    for (int k = 0; k < 8; k++) begin
      keep[8*k +: 8] = {8{mask[k]}};
    end
    return keep;
  endfunction

  task automatic compare(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
    o_checks++;
    if (got !== exp) begin
      o_errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    o_errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic reset_model();
    ref_pc = RESET_PC;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i);
    end
    ref_halted  = 1'b0;
    halt_seen   = 1'b0;
    req_pending = 1'b0;
    first_cycle = 1'b1;
  endtask

  // stores also update the reference memory image here.
  function automatic void expect_request(input logic we, input logic [XLEN-1:0] addr,
                                         input logic [XLEN-1:0] data, input logic [7:0] mask);
    logic [XLEN-1:0] keep;
    keep          = byte_lanes(mask);
    exp_req.we    = we;
    exp_req.addr  = addr;
    exp_req.wdata = data;
    exp_req.mask  = mask;
    req_pending   = 1'b1;
    if (we) begin
      ref_mem[addr[10:3]] = (ref_mem[addr[10:3]] & ~keep) | (data & keep);
    end
  endfunction

  function automatic void step_reference(input logic [31:0] inst);
    logic [6:0]      op;
    logic [2:0]      f3;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] wval;
    logic [XLEN-1:0] next_pc;
    logic [31:0]     word;
    logic            wr;
    op      = inst[6:0];
    f3      = inst[14:12];
    rs1     = ref_regs[inst[19:15]];
    rs2     = ref_regs[inst[24:20]];
    imm_i   = {{52{inst[31]}}, inst[31:20]};
    imm_s   = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    imm_u   = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j   = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = ref_pc + 64'd4;
    wr      = 1'b0;
    wval    = '0;
    if (inst == 32'h0010_0073) begin
      ref_halted = 1'b1;
    end else if (op == 7'b0110111) begin
      wr   = 1'b1;
      wval = imm_u;
    end else if (op == 7'b0010111) begin
      wr   = 1'b1;
      wval = ref_pc + imm_u;
    end else if (op == 7'b1101111) begin
      wr      = 1'b1;
      wval    = ref_pc + 64'd4;
      next_pc = (ref_pc + imm_j) & ~64'd1;
    end else if (op == 7'b1100111 && f3 == 3'b000) begin
      wr      = 1'b1;
      wval    = ref_pc + 64'd4;
      next_pc = (rs1 + imm_i) & ~64'd1;
    end else if (op == 7'b0010011 && f3 == 3'b000) begin
      wr   = 1'b1;
      wval = rs1 + imm_i;
    end else if (op == 7'b0111011 && f3 == 3'b000 && inst[31:25] == 7'b0000000) begin
      sum  = rs1 + rs2;
      wr   = 1'b1;
      wval = {{32{sum[31]}}, sum[31:0]};
    end else if (op == 7'b0000011 && f3 == 3'b010) begin
      addr = rs1 + imm_i;
      word = addr[2] ? ref_mem[addr[10:3]][63:32] : ref_mem[addr[10:3]][31:0];
      wr   = 1'b1;
      wval = {{32{word[31]}}, word};
      expect_request(1'b0, addr, '0, 8'h00);
    end else if (op == 7'b0100011 && f3 == 3'b011) begin
      expect_request(1'b1, rs1 + imm_s, rs2, 8'hff);
    end else if (op == 7'b0100011 && f3 == 3'b010) begin
      addr = rs1 + imm_s;
      if (addr[2]) begin
        expect_request(1'b1, addr, {rs2[31:0], 32'h0}, 8'hf0);
      end else begin
        expect_request(1'b1, addr, {32'h0, rs2[31:0]}, 8'h0f);
      end
    end
    if (wr && inst[11:7] != 5'd0) begin
      ref_regs[inst[11:7]] = wval;
    end
    ref_pc = next_pc;
  endfunction

  task automatic check_request();
    logic [XLEN-1:0] keep;
    if (halt_seen || !req_pending) begin
      report_failure("data request with no memory instruction to serve it");
    end else begin
      compare("o_dmem.we", i_dmem.we, exp_req.we);
      compare("o_dmem.addr", i_dmem.addr, exp_req.addr);
      if (exp_req.we) begin
        keep = byte_lanes(exp_req.mask);
        compare("o_dmem.mask", i_dmem.mask, exp_req.mask);
        compare("o_dmem.wdata", i_dmem.wdata & keep, exp_req.wdata & keep);
      end
      req_pending = 1'b0;
    end
  endtask

  always @(posedge i_clk) begin
    if (i_rst) begin
      reset_model();
    end else begin
      if (first_cycle) begin
        compare("o_halt", i_halt, 1'b0);
        compare("o_dmem.valid", i_dmem.valid, 1'b0);
        if (i_ifetch !== 1'b1) begin
          report_failure("no fetch in the first cycle after reset");
        end
      end
      first_cycle = 1'b0;
      if (i_dmem.valid === 1'b1) begin
        check_request();
      end
      if (i_halt === 1'b1 && !halt_seen) begin
        halt_seen = 1'b1;
        if (!ref_halted) begin
          report_failure("o_halt rose before any ebreak was executed");
        end
        if (req_pending) begin
          report_failure("an expected data request never appeared before halt");
        end
      end
      if (i_ifetch === 1'b1) begin
        if (ref_halted || halt_seen) begin
          report_failure("instruction fetch after ebreak");
        end else begin
          if (req_pending) begin
            report_failure("an expected data request never appeared");
          end
          req_pending = 1'b0;
          compare("o_pc", i_pc, ref_pc);
          step_reference(i_inst);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_top.sv */
// Core testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_top import rv_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int RAND_LEN     = 200;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JALR  = 7'b1100111;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;

  logic            clk;
  logic            rst;
  logic [31:0]     inst;
  logic [XLEN-1:0] rdata;
  logic [XLEN-1:0] pc;
  logic            ifetch;
  dmem_req_t       dmem_req;
  logic            halt;
  int              errors;
  int              checks;
  logic [31:0]     imem [0:511];
  logic [XLEN-1:0] dmem [0:255];
  int              prog_len;
  int              timeout_cycles;
  int              cycles;
  logic            finished;
  integer          seed;

  tb_clkgen #(.PERIOD_NS(4.0)) u_clkgen (.o_clk(clk));

  core_top #(.RESET_PC('0)) u_dut (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_inst   (inst),
    .i_rdata  (rdata),
    .o_pc     (pc),
    .o_ifetch (ifetch),
    .o_dmem   (dmem_req),
    .o_halt   (halt)
  );

  tb_checker #(.RESET_PC('0)) u_checker (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_pc     (pc),
    .i_ifetch (ifetch),
    .i_inst   (inst),
    .i_dmem   (dmem_req),
    .i_halt   (halt),
    .o_errors (errors),
    .o_checks (checks)
  );

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                        input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                        input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_addw(input logic [6:0] f7, input int rs2,
                                           input int rs1, input int rd);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0111011};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_directed();
    int tgt;
    emit(enc_u(20'h80000, 1, OP_LUI));
    emit(enc_i(-1, 1, 0, 2, OP_IMM));
    emit(enc_u(20'h7ffff, 5, OP_LUI));
    // the word sum overflows into a negative value.
    emit(enc_addw(7'b0000000, 5, 5, 6));
    emit(enc_u(20'h00001, 7, OP_AUIPC));
    emit(enc_i(5, 0, 0, 0, OP_IMM));
    emit(enc_u(20'h12345, 0, OP_LUI));
    emit(enc_addw(7'b0000000, 2, 1, 8));
    for (int r = 0; r <= 8; r++) begin
      emit(enc_s(8 * r, r, 0, 3));
    end
    emit(enc_j(8, 9));
    emit(enc_s(12'h200, 1, 0, 3));
    tgt = 4 * (prog_len + 3);
    emit(enc_i(tgt + 1, 0, 0, 10, OP_IMM));
    emit(enc_i(0, 10, 0, 11, OP_JALR));
    emit(enc_s(12'h208, 1, 0, 3));
    emit(enc_s(12'h48, 9, 0, 3));
    emit(enc_s(12'h50, 11, 0, 3));
    emit(enc_i(4, 0, 2, 12, OP_LOAD));
    emit(enc_i(8, 0, 2, 13, OP_LOAD));
    emit(enc_i(12'h104, 0, 2, 14, OP_LOAD));
    emit(enc_s(12'h60, 2, 0, 2));
    emit(enc_s(12'h64, 1, 0, 2));
    emit(enc_i(12'h64, 0, 2, 15, OP_LOAD));
    emit(enc_i(12'h100, 0, 0, 16, OP_IMM));
    emit(enc_s(12'h18, 13, 16, 3));
    for (int r = 12; r <= 15; r++) begin
      emit(enc_s(12'h70 + 8 * (r - 12), r, 0, 3));
    end
  endtask

  // jumps only go forward, and memory accesses use x0 as base to stay in range.
  task automatic build_random();
    int          kind;
    int          tgt;
    logic [31:0] v;
    logic [31:0] w;
    for (int n = 0; n < RAND_LEN; n++) begin
      kind = $unsigned($random(seed)) % 10;
      v    = $random(seed);
      w    = $random(seed);
      case (kind)
        0: emit(enc_u(w, v[4:0], OP_LUI));
        1: emit(enc_u(w, v[4:0], OP_AUIPC));
        2: emit(enc_i(w, v[9:5], 0, v[4:0], OP_IMM));
        3: emit(enc_addw(7'b0000000, v[14:10], v[9:5], v[4:0]));
        4: emit(enc_i(4 * w[8:0], 0, 2, v[4:0], OP_LOAD));
        5: emit(enc_s(4 * w[8:0], v[14:10], 0, 2));
        6: emit(enc_s(8 * w[7:0], v[14:10], 0, 3));
        7: emit(enc_j(4 * (1 + w[1:0] % 3), v[4:0]));
        8: begin
          tgt = 4 * (prog_len + 1 + w[1:0] % 3) + w[2];
          emit(enc_i(tgt, 0, 0, v[4:0], OP_JALR));
        end
        default: begin
          case (w[1:0])
            2'd0: emit({w[31:7], 7'b0001011});
            2'd1: emit(32'h0000_0073);
            2'd2: emit(enc_addw(7'b0100000, v[14:10], v[9:5], v[4:0]));
            default: emit(enc_i(w, v[9:5], 1, v[4:0], OP_IMM));
          endcase
        end
      endcase
    end
  endtask

  always @(negedge clk) begin
    inst <= imem[pc[10:2]];
    if (dmem_req.valid === 1'b1 && dmem_req.we === 1'b1) begin
      for (int k = 0; k < 8; k++) begin
        if (dmem_req.mask[k]) begin
          dmem[dmem_req.addr[10:3]][8*k +: 8] = dmem_req.wdata[8*k +: 8];
        end
      end
    end else if (dmem_req.valid === 1'b1) begin
      rdata <= dmem[dmem_req.addr[10:3]];
    end
  end

  always @(posedge clk) begin
    if (!finished) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
        $display("timeout: the core did not halt within %0d cycles", timeout_cycles);
        $display("summary: %0d checks, %0d errors", checks, errors + 1);
        $display("Some tests failed");
        $finish;
      end
    end
  end

  initial begin
    seed     = 67273;
    rst      = 1'b1;
    inst     = '0;
    rdata    = '0;
    finished = 1'b0;
    cycles   = 0;
    prog_len = 0;
    for (int i = 0; i < 512; i++) begin
      imem[i] = {i[24:0], 7'b0001011};
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = u_checker.fill_word(i);
    end
    build_directed();
    build_random();
    // two no-ops keep the last random jump short of the ebreak.
    emit(enc_i(0, 0, 0, 0, OP_IMM));
    emit(enc_i(0, 0, 0, 0, OP_IMM));
    emit(32'h0010_0073);
    emit(enc_s(12'h300, 1, 0, 3));
    timeout_cycles = 3 * prog_len + RESET_CYCLES + 50;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait (halt === 1'b1);
    repeat (8) @(posedge clk);
    finished = 1'b1;
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
rv_pkg.sv
mux_key.sv
idu.sv
ifu.sv
regfile.sv
alu.sv
lsu.sv
core_top.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

/* Bender.yml */
package:
  name: rv64i_core

sources:
  - files:
      - rv_pkg.sv
      - mux_key.sv
      - idu.sv
      - ifu.sv
      - regfile.sv
      - alu.sv
      - lsu.sv
      - core_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_checker.sv
      - tb_top.sv
